// File: common/vec_pkg.sv
// Shared fixed-point, vector, command and result types for the vector unit; use by scoped name
`default_nettype none

package vec_pkg;

    // Q16.16 coordinates
    localparam int COORD_BITS = 32;
    localparam int Q_BITS     = 16;
    localparam int PROD_BITS  = 2 * COORD_BITS;

    // Entries in each of the command and result FIFOs
    localparam int FIFO_DEPTH = 16;

    typedef logic signed [COORD_BITS-1:0] coord_t;

    // Full-width product before the fraction bits are shifted out
    typedef logic signed [PROD_BITS-1:0] prod_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_DOT   = 2'd1,
        OP_CROSS = 2'd2,
        OP_SCALE = 2'd3
    } vec_op_t;

    typedef struct packed {
        vec_op_t op;
        vec3_t   x;
        vec3_t   y;
        coord_t  a;
    } vec_cmd_t;

    // Dot puts its scalar in v.x and clears v.y and v.z
    typedef struct packed {
        vec_op_t op;
        vec3_t   v;
    } vec_result_t;

    typedef enum logic {
        CTRL_READ  = 1'b0,
        CTRL_WRITE = 1'b1
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: compile.f
+incdir+tests
common/vec_pkg.sv
fifo/vec_fifo.sv
vec_alu/vec_arith.sv
vec_alu/vec_alu_ctrl.sv
src/vec_unit.sv
tests/vec_unit_tb.sv

// File: fifo/vec_fifo.sv
// Single-clock show-ahead FIFO that buffers the commands and results of the vector unit
`timescale 1ns/1ns
`default_nettype none

module vec_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             write,
    input  wire logic [WIDTH-1:0] din,
    output logic                  full,
    input  wire logic             read,
    output logic [WIDTH-1:0]      dout,
    output logic                  empty
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       wr_ok;
    logic                       rd_ok;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);

    // A read while full frees the slot the write lands in
    assign rd_ok = read && !empty;
    assign wr_ok = write && (!full || read);

    // Head entry is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the vector unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module vec_unit_tb -f compile.f -o vec_unit_sim

./obj_dir/vec_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// File: src/vec_unit.sv
// Top of the vector unit, joining command FIFO, controller, datapath and result FIFO
`timescale 1ns/1ns
`default_nettype none

module vec_unit (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire vec_pkg::vec_cmd_t    cmd,
    input  wire logic                 cmd_write,
    output logic                      cmd_full,
    output vec_pkg::vec_result_t      result,
    input  wire logic                 result_read,
    output logic                      result_empty
);

    vec_pkg::vec_cmd_t    cmd_head;
    vec_pkg::vec_result_t computed;
    vec_pkg::vec_result_t res_data;
    logic                 cmd_empty;
    logic                 cmd_pop;
    logic                 res_full;
    logic                 res_push;

    vec_fifo #(
        .WIDTH ($bits(vec_pkg::vec_cmd_t)),
        .DEPTH (vec_pkg::FIFO_DEPTH)
    ) i_cmd_fifo (
        .clock (clock),
        .reset (reset),
        .write (cmd_write),
        .din   (cmd),
        .full  (cmd_full),
        .read  (cmd_pop),
        .dout  (cmd_head),
        .empty (cmd_empty)
    );

    vec_arith i_vec_arith (
        .cmd (cmd_head),
        .res (computed)
    );

    vec_alu_ctrl i_vec_alu_ctrl (
        .clock     (clock),
        .reset     (reset),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .computed  (computed),
        .res_full  (res_full),
        .res_push  (res_push),
        .res_data  (res_data)
    );

    vec_fifo #(
        .WIDTH ($bits(vec_pkg::vec_result_t)),
        .DEPTH (vec_pkg::FIFO_DEPTH)
    ) i_result_fifo (
        .clock (clock),
        .reset (reset),
        .write (res_push),
        .din   (res_data),
        .full  (res_full),
        .read  (result_read),
        .dout  (result),
        .empty (result_empty)
    );

endmodule

`default_nettype wire

// File: tests/vec_unit_ref.svh
// Reference arithmetic for the vector unit testbench, included inside the testbench module
`ifndef VEC_UNIT_REF_SVH
`define VEC_UNIT_REF_SVH

// Exact Q32.32 product of two Q16.16 values
function automatic longint full_product(input vec_pkg::coord_t a, input vec_pkg::coord_t b);
    longint wide_a;
    longint wide_b;
    wide_a = longint'(a);
    wide_b = longint'(b);
    return wide_a * wide_b;
endfunction

// Divide by 2^Q and round toward minus infinity
function automatic longint floor_fraction(input longint p);
    longint q;
    q = p / (longint'(1) << vec_pkg::Q_BITS);
    if (p < 0 && (q << vec_pkg::Q_BITS) != p) begin
        q = q - 1;
    end
    return q;
endfunction

// Results wrap to 32 bits
function automatic vec_pkg::coord_t low_word(input longint v);
    return v[31:0];
endfunction

function automatic vec_pkg::vec_result_t expected_result(input vec_pkg::vec_cmd_t c);
    vec_pkg::vec_result_t r;
    longint dot;
    r.op = c.op;
    r.v = '0;
    case (c.op)
        vec_pkg::OP_ADD: begin
            r.v.x = low_word(longint'(c.x.x) + longint'(c.y.x));
            r.v.y = low_word(longint'(c.x.y) + longint'(c.y.y));
            r.v.z = low_word(longint'(c.x.z) + longint'(c.y.z));
        end
        vec_pkg::OP_DOT: begin
            dot = floor_fraction(full_product(c.x.x, c.y.x))
                + floor_fraction(full_product(c.x.y, c.y.y))
                + floor_fraction(full_product(c.x.z, c.y.z));
            r.v.x = low_word(dot);
        end
        vec_pkg::OP_CROSS: begin
            r.v.x = low_word(floor_fraction(full_product(c.x.y, c.y.z)
                                            - full_product(c.x.z, c.y.y)));
            r.v.y = low_word(floor_fraction(full_product(c.x.z, c.y.x)
                                            - full_product(c.x.x, c.y.z)));
            r.v.z = low_word(floor_fraction(full_product(c.x.x, c.y.y)
                                            - full_product(c.x.y, c.y.x)));
        end
        default: begin
            r.v.x = low_word(floor_fraction(full_product(c.x.x, c.a)));
            r.v.y = low_word(floor_fraction(full_product(c.x.y, c.a)));
            r.v.z = low_word(floor_fraction(full_product(c.x.z, c.a)));
        end
    endcase
    return r;
endfunction

`endif

// File: tests/vec_unit_tb.sv
// Testbench for the vector unit; compile with compile.f and run vec_unit_tb as top
`timescale 1ns/1ns
`default_nettype none

module vec_unit_tb;

    localparam int WAIT_LIMIT   = 200;
    localparam int RANDOM_COUNT = 300;

    // Result FIFO, the result held by the controller, then the command FIFO
    localparam int FILL_WRITES  = 2 * vec_pkg::FIFO_DEPTH + 1;

    logic                 clock;
    logic                 reset;
    vec_pkg::vec_cmd_t    cmd;
    logic                 cmd_write;
    logic                 cmd_full;
    vec_pkg::vec_result_t result;
    logic                 result_read;
    logic                 result_empty;

    vec_pkg::vec_result_t expected_q[$];
    integer               seed;
    int                   check_count;
    int                   error_count;
    int                   result_count;

    `include "vec_unit_ref.svh"

    vec_unit i_vec_unit (
        .clock        (clock),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_write    (cmd_write),
        .cmd_full     (cmd_full),
        .result       (result),
        .result_read  (result_read),
        .result_empty (result_empty)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $finish;
    endtask

    task automatic compare_result(input vec_pkg::vec_result_t got,
                                  input vec_pkg::vec_result_t exp);
        check_count++;
        if (got.op !== exp.op) begin
            error_count++;
            $display("error result.op got %h expected %h", got.op, exp.op);
        end
        if (got.v.x !== exp.v.x) begin
            error_count++;
            $display("error result.v.x got %h expected %h", got.v.x, exp.v.x);
        end
        if (got.v.y !== exp.v.y) begin
            error_count++;
            $display("error result.v.y got %h expected %h", got.v.y, exp.v.y);
        end
        if (got.v.z !== exp.v.z) begin
            error_count++;
            $display("error result.v.z got %h expected %h", got.v.z, exp.v.z);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    function automatic vec_pkg::vec3_t make_vec(input vec_pkg::coord_t x,
                                                input vec_pkg::coord_t y,
                                                input vec_pkg::coord_t z);
        vec_pkg::vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic vec_pkg::vec_cmd_t make_cmd(input vec_pkg::vec_op_t op,
                                                   input vec_pkg::vec3_t x,
                                                   input vec_pkg::vec3_t y,
                                                   input vec_pkg::coord_t a);
        vec_pkg::vec_cmd_t c;
        c.op = op;
        c.x = x;
        c.y = y;
        c.a = a;
        return c;
    endfunction

    function automatic vec_pkg::vec_cmd_t random_cmd();
        logic [31:0] r;
        r = $random(seed);
        return make_cmd(vec_pkg::vec_op_t'(r[1:0]),
                        make_vec($random(seed), $random(seed), $random(seed)),
                        make_vec($random(seed), $random(seed), $random(seed)),
                        $random(seed));
    endfunction

    // Write is only issued when the FIFO has room, so every write is accepted
    task automatic write_cmd(input vec_pkg::vec_cmd_t c);
        int waited;
        waited = 0;
        @(negedge clock);
        while (cmd_full) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout("room in the command FIFO");
            @(negedge clock);
        end
        @(posedge clock);
        cmd <= c;
        cmd_write <= 1'b1;
        expected_q.push_back(expected_result(c));
        @(posedge clock);
        cmd_write <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout("the outstanding results");
            @(posedge clock);
        end
        // Idle cycles catch a stray extra result
        repeat (4) @(posedge clock);
    endtask

    // Scoreboard; the head entry is taken at the next edge
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && result_read && !result_empty) begin
                result_count++;
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("a result came out with no command outstanding");
                end else begin
                    compare_result(result, expected_q.pop_front());
                end
            end
        end
    end

    initial begin
        int errors_before;
        int writes;
        int results_before;
        seed = 35676;
        check_count = 0;
        error_count = 0;
        result_count = 0;
        reset = 1'b1;
        cmd = '0;
        cmd_write = 1'b0;
        result_read = 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        errors_before = error_count;
        @(negedge clock);
        compare_flag("result_empty", result_empty, 1'b1);
        compare_flag("cmd_full", cmd_full, 1'b0);
        end_test("reset", errors_before);

        // 1.5, -2.25, 2.0 against 0.75, 3.0, -0.5
        errors_before = error_count;
        @(posedge clock);
        result_read <= 1'b1;
        write_cmd(make_cmd(vec_pkg::OP_ADD, make_vec(32'h0001_8000, 32'hFFFD_C000, 32'h0002_0000),
                           make_vec(32'h0000_C000, 32'h0003_0000, 32'hFFFF_8000), 32'h0));
        write_cmd(make_cmd(vec_pkg::OP_DOT, make_vec(32'h0001_8000, 32'hFFFD_C000, 32'h0002_0000),
                           make_vec(32'h0000_C000, 32'h0003_0000, 32'hFFFF_8000), 32'h0));
        write_cmd(make_cmd(vec_pkg::OP_CROSS, make_vec(32'h0001_8000, 32'hFFFD_C000, 32'h0002_0000),
                           make_vec(32'h0000_C000, 32'h0003_0000, 32'hFFFF_8000), 32'h0));
        write_cmd(make_cmd(vec_pkg::OP_SCALE, make_vec(32'h0001_8000, 32'hFFFD_C000, 32'h0002_0000),
                           make_vec(32'h0, 32'h0, 32'h0), 32'hFFFD_C000));
        wait_drained();
        end_test("directed", errors_before);

        // Negative LSB-sized products against 0.5
        errors_before = error_count;
        write_cmd(make_cmd(vec_pkg::OP_SCALE, make_vec(32'hFFFF_FFFF, 32'h1, 32'hFFFF_FFFD),
                           make_vec(32'h0, 32'h0, 32'h0), 32'h0000_8000));
        write_cmd(make_cmd(vec_pkg::OP_DOT, make_vec(32'hFFFF_FFFF, 32'h0, 32'h0),
                           make_vec(32'h0000_8000, 32'h0, 32'h0), 32'h0));
        write_cmd(make_cmd(vec_pkg::OP_CROSS, make_vec(32'hFFFF_FFFF, 32'h0, 32'h0),
                           make_vec(32'h0, 32'h0000_8000, 32'h0), 32'h0));
        wait_drained();
        end_test("rounding", errors_before);

        errors_before = error_count;
        repeat (RANDOM_COUNT) write_cmd(random_cmd());
        wait_drained();
        end_test("random", errors_before);

        // Result FIFO fills first, then the command FIFO
        errors_before = error_count;
        results_before = result_count;
        writes = 0;
        @(posedge clock);
        result_read <= 1'b0;
        @(negedge clock);
        while (!cmd_full) begin
            if (writes > 4 * vec_pkg::FIFO_DEPTH) fail_timeout("cmd_full to rise");
            write_cmd(random_cmd());
            writes++;
            @(negedge clock);
        end
        if (writes != FILL_WRITES) begin
            error_count++;
            $display("error writes before cmd_full got %h expected %h", writes, FILL_WRITES);
        end
        compare_flag("result_empty", result_empty, 1'b0);
        @(posedge clock);
        result_read <= 1'b1;
        wait_drained();
        if (result_count - results_before != writes) begin
            error_count++;
            $display("drained %0d results but %0d commands were accepted",
                     result_count - results_before, writes);
        end
        end_test("backpressure", errors_before);

        $display("checks %0d, results %0d, errors %0d", check_count, result_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vec_alu/vec_alu_ctrl.sv
// Two-state controller that pops a command, holds its result and pushes it to the result FIFO
`timescale 1ns/1ns
`default_nettype none

module vec_alu_ctrl (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 cmd_empty,
    output logic                      cmd_pop,
    input  wire vec_pkg::vec_result_t computed,
    input  wire logic                 res_full,
    output logic                      res_push,
    output vec_pkg::vec_result_t      res_data
);

    vec_pkg::ctrl_state_t state;
    vec_pkg::ctrl_state_t next_state;
    vec_pkg::vec_result_t res_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= vec_pkg::CTRL_READ;
            res_data <= '0;
        end else begin
            state    <= next_state;
            res_data <= res_next;
        end
    end

    always_comb begin
        next_state = state;
        res_next   = res_data;
        cmd_pop    = 1'b0;
        res_push   = 1'b0;

        case (state)
            vec_pkg::CTRL_READ: begin
                // Head command is already on the datapath input
                if (!cmd_empty) begin
                    res_next   = computed;
                    cmd_pop    = 1'b1;
                    next_state = vec_pkg::CTRL_WRITE;
                end
            end
            vec_pkg::CTRL_WRITE: begin
                // Hold the result until the output has room
                if (!res_full) begin
                    res_push   = 1'b1;
                    next_state = vec_pkg::CTRL_READ;
                end
            end
            default: begin
                next_state = vec_pkg::CTRL_READ;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: vec_alu/vec_arith.sv
// Combinational Q16.16 datapath for add, dot, cross and scale, selected by the command's op code
`timescale 1ns/1ns
`default_nettype none

module vec_arith (
    input  wire vec_pkg::vec_cmd_t cmd,
    output vec_pkg::vec_result_t   res
);

    // Full 64-bit signed product of two coordinates
    function automatic vec_pkg::prod_t fx_mul(input vec_pkg::coord_t a, input vec_pkg::coord_t b);
        vec_pkg::prod_t wide_a;
        vec_pkg::prod_t wide_b;
        wide_a = vec_pkg::prod_t'(a);
        wide_b = vec_pkg::prod_t'(b);
        return wide_a * wide_b;
    endfunction

    // Arithmetic shift rounds toward minus infinity, upper bits wrap away
    function automatic vec_pkg::coord_t fx_narrow(input vec_pkg::prod_t p);
        vec_pkg::prod_t shifted;
        shifted = p >>> vec_pkg::Q_BITS;
        return shifted[vec_pkg::COORD_BITS-1:0];
    endfunction

    vec_pkg::vec3_t x;
    vec_pkg::vec3_t y;
    vec_pkg::vec3_t sum;

    // Dot terms
    vec_pkg::prod_t p_xx;
    vec_pkg::prod_t p_yy;
    vec_pkg::prod_t p_zz;
    vec_pkg::prod_t dot_sum;

    // Cross terms, named after the x and y components multiplied
    vec_pkg::prod_t p_yz;
    vec_pkg::prod_t p_zy;
    vec_pkg::prod_t p_zx;
    vec_pkg::prod_t p_xz;
    vec_pkg::prod_t p_xy;
    vec_pkg::prod_t p_yx;

    // Scale terms
    vec_pkg::prod_t p_ax;
    vec_pkg::prod_t p_ay;
    vec_pkg::prod_t p_az;

    assign x = cmd.x;
    assign y = cmd.y;

    assign sum.x = x.x + y.x;
    assign sum.y = x.y + y.y;
    assign sum.z = x.z + y.z;

    assign p_xx = fx_mul(x.x, y.x);
    assign p_yy = fx_mul(x.y, y.y);
    assign p_zz = fx_mul(x.z, y.z);

    // Each term is shifted before the sum
    assign dot_sum = (p_xx >>> vec_pkg::Q_BITS)
                   + (p_yy >>> vec_pkg::Q_BITS)
                   + (p_zz >>> vec_pkg::Q_BITS);

    assign p_yz = fx_mul(x.y, y.z);
    assign p_zy = fx_mul(x.z, y.y);
    assign p_zx = fx_mul(x.z, y.x);
    assign p_xz = fx_mul(x.x, y.z);
    assign p_xy = fx_mul(x.x, y.y);
    assign p_yx = fx_mul(x.y, y.x);

    assign p_ax = fx_mul(x.x, cmd.a);
    assign p_ay = fx_mul(x.y, cmd.a);
    assign p_az = fx_mul(x.z, cmd.a);

    always_comb begin
        res.op = cmd.op;
        res.v  = '0;
        case (cmd.op)
            vec_pkg::OP_ADD: begin
                res.v = sum;
            end
            vec_pkg::OP_DOT: begin
                res.v.x = dot_sum[vec_pkg::COORD_BITS-1:0];
            end
            vec_pkg::OP_CROSS: begin
                // Differences stay at full width until the final shift
                res.v.x = fx_narrow(p_yz - p_zy);
                res.v.y = fx_narrow(p_zx - p_xz);
                res.v.z = fx_narrow(p_xy - p_yx);
            end
            vec_pkg::OP_SCALE: begin
                res.v.x = fx_narrow(p_ax);
                res.v.y = fx_narrow(p_ay);
                res.v.z = fx_narrow(p_az);
            end
            default: begin
                res.v = '0;
            end
        endcase
    end

endmodule

`default_nettype wire
